// File: npu_defs.svh
// ******************************
// Widths, tile geometry, slot counts and opcodes of the execution unit
// ******************************
`ifndef NPU_DEFS_SVH
`define NPU_DEFS_SVH

// Element and accumulator widths
`define NPU_DATA_W        8
`define NPU_ACC_W         24

// Tile geometry
`define NPU_TILE_ELEMS    4
`define NPU_MAX_DIM       8
`define NPU_TILES_PER_VEC 2

// Buffer slots and address width
`define NPU_VEC_SLOTS     8
`define NPU_W_SLOTS       4
`define NPU_BUF_AW        7

// Opcodes
`define NPU_OP_NOP        5'd0
`define NPU_OP_LOAD_V     5'd1
`define NPU_OP_LOAD_M     5'd2
`define NPU_OP_GEMV       5'd4
`define NPU_OP_RELU       5'd5

`endif

// File: npu_pkg.sv
// ******************************
// Command, data and internal control types
// ******************************
`include "npu_defs.svh"

package npu_pkg;

    // Scalars
    typedef logic signed [`NPU_DATA_W-1:0] elem_t;
    typedef logic [$clog2(`NPU_VEC_SLOTS)-1:0] slot_t;
    typedef logic [$clog2(`NPU_MAX_DIM)-1:0] row_t;
    typedef logic [$clog2(`NPU_MAX_DIM):0] dim_t;
    typedef logic [$clog2(`NPU_TILES_PER_VEC)-1:0] tidx_t;

    // One tile of elements, element 0 in the low byte
    typedef elem_t [`NPU_TILE_ELEMS-1:0] tile_t;
    typedef elem_t [`NPU_MAX_DIM-1:0] result_t;

    // Load view, tile carried in the command
    typedef struct packed {
        tile_t tile;
        slot_t slot;
        row_t  row;
        tidx_t tile_idx;
    } load_view_t;

    // Spare bits so both views span the same word
    localparam int CP_PAD_W = $bits(load_view_t) - 3 * $bits(slot_t) - 2 * $bits(dim_t);

    // Compute view, RELU works on x_id
    typedef struct packed {
        logic [CP_PAD_W-1:0] rsvd;
        slot_t               x_id;
        slot_t               w_id;
        slot_t               b_id;
        dim_t                rows;
        dim_t                cols;
    } compute_view_t;

    typedef union packed {
        load_view_t    ld;
        compute_view_t cp;
    } cmd_u;

    typedef struct packed {
        logic [4:0] opcode;
        cmd_u       payload;
    } cmd_t;

    // Buffer write port
    typedef struct packed {
        logic                  en;
        logic [`NPU_BUF_AW-1:0] addr;
        tile_t                 tile;
    } buf_wr_t;

    // GEMV datapath control, aligned with buffer read data
    typedef struct packed {
        logic                       load_x;
        logic                       load_b;
        logic                       w_valid;
        tidx_t                      tile_idx;
        logic                       last_tile_of_row;
        row_t                       row;
        logic [`NPU_TILE_ELEMS-1:0] keep;
    } gemv_ctl_t;

    // Result store control
    typedef struct packed {
        logic clear;
        logic tile_en;
        row_t base;
        dim_t limit;
        logic relu;
    } res_wr_t;

endpackage

// File: tile_buffer.sv
// ******************************
// Tile memory, one write port and a registered read port
// ******************************
`timescale 1ns/1ps
`include "npu_defs.svh"

module tile_buffer #(
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  npu_pkg::buf_wr_t       wr,
    input  logic [`NPU_BUF_AW-1:0] rd_addr,
    output npu_pkg::tile_t         rd_data
);
    import npu_pkg::*;

    // Index bits actually decoded
    localparam int AW = $clog2(DEPTH);

    tile_t mem [DEPTH];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[AW-1:0]] <= wr.tile;
        end
    end

    // Read data valid one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[AW-1:0]];
    end

    // Slot, row and tile index from the command must land inside this memory
    a_wr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        wr.en |-> (int'(wr.addr) < DEPTH)
    ) else $error("tile_buffer write address %0d out of range", wr.addr);

endmodule

// File: gemv_engine.sv
// ******************************
// GEMV datapath: x and bias tiles, tile MAC, row saturation
// ******************************
`timescale 1ns/1ps
`include "npu_defs.svh"

module gemv_engine (
    input  logic               clk,
    input  logic               rst,
    input  npu_pkg::gemv_ctl_t ctl,
    input  npu_pkg::tile_t     tile_in,
    output logic               row_valid,
    output npu_pkg::row_t      row_idx,
    output npu_pkg::elem_t     row_value
);
    import npu_pkg::*;

    localparam int EW = $clog2(`NPU_TILE_ELEMS);
    localparam int TW = $clog2(`NPU_TILES_PER_VEC);
    localparam int SAT_MAX = 2 ** (`NPU_DATA_W - 1) - 1;
    localparam int SAT_MIN = -(2 ** (`NPU_DATA_W - 1));

    tile_t                        x_q [`NPU_TILES_PER_VEC];
    tile_t                        b_q [`NPU_TILES_PER_VEC];
    logic signed [`NPU_ACC_W-1:0] acc_q;
    logic signed [`NPU_ACC_W-1:0] dot;
    logic signed [`NPU_ACC_W-1:0] row_sum;
    elem_t                        bias;
    elem_t                        row_sat;
    logic                         row_done;

    // Weight tile times the x tile at the same column position
    always_comb begin
        dot = '0;
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            dot = dot + tile_in[i] * x_q[ctl.tile_idx][i];
        end
    end

    // Bias element picked by row, upper bits select the tile
    assign bias     = b_q[ctl.row[EW +: TW]][ctl.row[EW-1:0]];
    assign row_done = ctl.w_valid && ctl.last_tile_of_row;

    // Finished row: partial sum, last tile, bias, then clamp to 8 bits
    always_comb begin
        row_sum = acc_q + dot + bias;
        if (row_sum > SAT_MAX) begin
            row_sat = elem_t'(SAT_MAX);
        end else if (row_sum < SAT_MIN) begin
            row_sat = elem_t'(SAT_MIN);
        end else begin
            row_sat = elem_t'(row_sum);
        end
    end

    // Operand tiles and row output
    always_ff @(posedge clk) begin
        if (ctl.load_x) begin
            // Columns past cols come in masked off
            for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
                x_q[ctl.tile_idx][i] <= ctl.keep[i] ? tile_in[i] : '0;
            end
        end
        if (ctl.load_b) begin
            b_q[ctl.tile_idx] <= tile_in;
        end
        if (row_done) begin
            row_idx   <= ctl.row;
            row_value <= row_sat;
        end
    end

    // Accumulator, back to zero after every row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_q     <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= row_done;
            if (ctl.w_valid) begin
                acc_q <= ctl.last_tile_of_row ? '0 : acc_q + dot;
            end
        end
    end

endmodule

// File: result_store.sv
// ******************************
// Result register file, written by GEMV rows or ReLU tiles
// ******************************
`timescale 1ns/1ps
`include "npu_defs.svh"

module result_store (
    input  logic             clk,
    input  logic             rst,
    input  npu_pkg::res_wr_t wr,
    input  npu_pkg::tile_t   tile_in,
    input  logic             row_valid,
    input  npu_pkg::row_t    row_idx,
    input  npu_pkg::elem_t   row_value,
    output npu_pkg::result_t result
);
    import npu_pkg::*;

    tile_t tile_act;

    // Optional ReLU on the incoming vector tile
    always_comb begin
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            tile_act[i] = (wr.relu && tile_in[i] < 0) ? '0 : tile_in[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (wr.clear) begin
            // New compute command, elements past the count read as zero
            result <= '0;
        end else begin
            if (wr.tile_en) begin
                for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
                    if (int'(wr.base) + i < int'(wr.limit) &&
                        int'(wr.base) + i < `NPU_MAX_DIM) begin
                        result[int'(wr.base) + i] <= tile_act[i];
                    end
                end
            end
            // GEMV rows, one element at a time
            if (row_valid) begin
                result[row_idx] <= row_value;
            end
        end
    end

    // RELU tiles and GEMV rows belong to different commands
    a_one_writer: assert property (
        @(posedge clk) disable iff (rst)
        !(wr.tile_en && row_valid)
    ) else $error("result_store tile and row write in the same cycle");

endmodule

// File: exec_ctrl.sv
// ******************************
// Command handshake FSM, buffer read sequencing, datapath control
// ******************************
`timescale 1ns/1ps
`include "npu_defs.svh"

module exec_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_req,
    input  npu_pkg::cmd_t          cmd,
    output logic                   cmd_ack,
    output npu_pkg::buf_wr_t       vec_wr,
    output npu_pkg::buf_wr_t       w_wr,
    output logic [`NPU_BUF_AW-1:0] vec_rd_addr,
    output logic [`NPU_BUF_AW-1:0] w_rd_addr,
    output npu_pkg::gemv_ctl_t     gemv_ctl,
    output npu_pkg::res_wr_t       res_wr
);
    import npu_pkg::*;

    localparam int EW = $clog2(`NPU_TILE_ELEMS);

    typedef enum logic [3:0] {
        IDLE,
        LOAD,
        READ_X,
        READ_B,
        STREAM_W,
        DRAIN,
        RELU,
        ACK,
        WAIT_DROP
    } state_t;

    state_t        state_q;
    tidx_t         tile_q;
    row_t          row_q;
    tidx_t         last_tile;
    logic          tile_wrap;
    logic          row_last;
    load_view_t    ld;
    compute_view_t cp;
    gemv_ctl_t     gemv_c;
    res_wr_t       res_c;

    // Host holds cmd until cmd_ack, so it is decoded in place
    assign ld = cmd.payload.ld;
    assign cp = cmd.payload.cp;

    // Last tile of a cols-long row, one tile even when cols is zero
    assign last_tile = (cp.cols == '0) ? '0 : tidx_t'((cp.cols - 1'b1) >> EW);
    assign tile_wrap = (tile_q == last_tile);
    assign row_last  = ({1'b0, row_q} == cp.rows - 1'b1);

    // Load writes happen in the single LOAD cycle
    always_comb begin
        vec_wr.en   = (state_q == LOAD) && (cmd.opcode == `NPU_OP_LOAD_V);
        vec_wr.addr = `NPU_BUF_AW'({ld.slot, ld.tile_idx});
        vec_wr.tile = ld.tile;
        w_wr.en     = (state_q == LOAD) && (cmd.opcode == `NPU_OP_LOAD_M);
        w_wr.addr   = `NPU_BUF_AW'({ld.slot, ld.row, ld.tile_idx});
        w_wr.tile   = ld.tile;
    end

    // Read addresses, bias slot only while reading bias
    assign vec_rd_addr = `NPU_BUF_AW'({((state_q == READ_B) ? cp.b_id : cp.x_id), tile_q});
    assign w_rd_addr   = `NPU_BUF_AW'({cp.w_id, row_q, tile_q});

    // Control for the data that arrives next cycle
    always_comb begin
        gemv_c          = '0;
        gemv_c.tile_idx = tile_q;
        gemv_c.row      = row_q;
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            gemv_c.keep[i] = (int'(tile_q) * `NPU_TILE_ELEMS + i) < int'(cp.cols);
        end
        res_c       = '0;
        res_c.base  = row_t'({tile_q, {EW{1'b0}}});
        res_c.limit = cp.cols;
        case (state_q)
            IDLE: begin
                res_c.clear = cmd_req &&
                    (cmd.opcode == `NPU_OP_GEMV || cmd.opcode == `NPU_OP_RELU);
            end
            READ_X:   gemv_c.load_x = 1'b1;
            READ_B:   gemv_c.load_b = 1'b1;
            STREAM_W: begin
                gemv_c.w_valid          = 1'b1;
                gemv_c.last_tile_of_row = tile_wrap;
            end
            RELU: begin
                res_c.tile_en = 1'b1;
                res_c.relu    = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            tile_q   <= '0;
            row_q    <= '0;
            cmd_ack  <= 1'b0;
            gemv_ctl <= '0;
            res_wr   <= '0;
        end else begin
            // One cycle delay to meet the buffer read latency
            gemv_ctl <= gemv_c;
            res_wr   <= res_c;
            case (state_q)
                IDLE: begin
                    if (cmd_req) begin
                        tile_q <= '0;
                        row_q  <= '0;
                        case (cmd.opcode)
                            `NPU_OP_GEMV: state_q <= READ_X;
                            `NPU_OP_RELU: state_q <= RELU;
                            // Loads, NOP and unknown opcodes
                            default:      state_q <= LOAD;
                        endcase
                    end
                end
                LOAD: state_q <= ACK;
                // Both x tiles, then both bias tiles
                READ_X: begin
                    tile_q <= tile_q + 1'b1;
                    if (tile_q == tidx_t'(`NPU_TILES_PER_VEC - 1)) begin
                        tile_q  <= '0;
                        state_q <= READ_B;
                    end
                end
                READ_B: begin
                    tile_q <= tile_q + 1'b1;
                    if (tile_q == tidx_t'(`NPU_TILES_PER_VEC - 1)) begin
                        tile_q  <= '0;
                        state_q <= (cp.rows == '0) ? DRAIN : STREAM_W;
                    end
                end
                // One weight tile per cycle, row by row
                STREAM_W: begin
                    if (tile_wrap) begin
                        tile_q <= '0;
                        row_q  <= row_q + 1'b1;
                        if (row_last) begin
                            state_q <= DRAIN;
                        end
                    end else begin
                        tile_q <= tile_q + 1'b1;
                    end
                end
                RELU: begin
                    tile_q <= tile_q + 1'b1;
                    if (tile_wrap) begin
                        state_q <= DRAIN;
                    end
                end
                // Last row or tile still in flight
                DRAIN: state_q <= ACK;
                ACK: begin
                    cmd_ack <= 1'b1;
                    state_q <= WAIT_DROP;
                end
                // Hold ack until the host lets go of req
                WAIT_DROP: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Four-phase handshake, ack only answers a pending request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> cmd_req
    ) else $error("cmd_ack rose without cmd_req");

endmodule

// File: npu_exec_top.sv
// ******************************
// Execution unit top, controller plus buffers and datapath
// ******************************
`timescale 1ns/1ps
`include "npu_defs.svh"

module npu_exec_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_req,
    input  npu_pkg::cmd_t    cmd,
    output logic             cmd_ack,
    output npu_pkg::result_t result
);
    import npu_pkg::*;

    buf_wr_t                vec_wr;
    buf_wr_t                w_wr;
    logic [`NPU_BUF_AW-1:0] vec_rd_addr;
    logic [`NPU_BUF_AW-1:0] w_rd_addr;
    tile_t                  vec_rd_data;
    tile_t                  w_rd_data;
    tile_t                  gemv_tile;
    gemv_ctl_t              gemv_ctl;
    res_wr_t                res_wr;
    logic                   row_valid;
    row_t                   row_idx;
    elem_t                  row_value;

    exec_ctrl exec_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_ack     (cmd_ack),
        .vec_wr      (vec_wr),
        .w_wr        (w_wr),
        .vec_rd_addr (vec_rd_addr),
        .w_rd_addr   (w_rd_addr),
        .gemv_ctl    (gemv_ctl),
        .res_wr      (res_wr)
    );

    // x and bias vectors, two tiles per slot
    tile_buffer #(.DEPTH(16)) vec_buf (
        .clk     (clk),
        .rst     (rst),
        .wr      (vec_wr),
        .rd_addr (vec_rd_addr),
        .rd_data (vec_rd_data)
    );

    // Weights, slot by row by tile
    tile_buffer #(.DEPTH(64)) w_buf (
        .clk     (clk),
        .rst     (rst),
        .wr      (w_wr),
        .rd_addr (w_rd_addr),
        .rd_data (w_rd_data)
    );

    // Weight data while streaming, vector data for x and bias
    assign gemv_tile = gemv_ctl.w_valid ? w_rd_data : vec_rd_data;

    gemv_engine gemv_engine_inst (
        .clk       (clk),
        .rst       (rst),
        .ctl       (gemv_ctl),
        .tile_in   (gemv_tile),
        .row_valid (row_valid),
        .row_idx   (row_idx),
        .row_value (row_value)
    );

    result_store result_store_inst (
        .clk       (clk),
        .rst       (rst),
        .wr        (res_wr),
        .tile_in   (vec_rd_data),
        .row_valid (row_valid),
        .row_idx   (row_idx),
        .row_value (row_value),
        .result    (result)
    );

endmodule

// File: tb_npu_exec.sv
// ******************************
// Random-stimulus testbench with reference model for the NPU execution unit
// ******************************
`timescale 1ns/1ps
`include "npu_defs.svh"

module tb_npu_exec;
    import npu_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int N_RELU     = 20;
    localparam int N_GEMV     = 20;
    localparam int N_OVER     = 6;
    localparam int N_NOP      = 8;
    localparam int N_HOLD     = 8;
    localparam int N_LAT      = 16;
    // Per-command cycle budget covers the longest GEMV plus hold
    localparam int FILL_CMDS  = `NPU_VEC_SLOTS * `NPU_TILES_PER_VEC +
                                `NPU_W_SLOTS * `NPU_MAX_DIM * `NPU_TILES_PER_VEC;
    localparam int GEMV_CMDS  = 5 + `NPU_MAX_DIM * `NPU_TILES_PER_VEC;
    localparam int MAX_CMDS   = FILL_CMDS + N_RELU * 3 + N_GEMV * GEMV_CMDS + N_OVER * 4 +
                                N_NOP + N_HOLD + N_LAT + 1;
    localparam int CMD_CYCLES = 48;
    localparam int TIMEOUT_NS = (RST_CYCLES + 16 + MAX_CMDS * CMD_CYCLES) * CLK_PERIOD;

    logic    clk;
    logic    rst;
    logic    cmd_req;
    cmd_t    cmd;
    logic    cmd_ack;
    result_t result;

    integer     seed;
    int         errors;
    int         checks;
    int         tests;
    int         failed_tests;
    int         test_errors;
    int         test_checks;
    string      test_name;
    logic [4:0] last_opcode;

    // Reference model of both buffers and of the result vector
    elem_t   vec_m [`NPU_VEC_SLOTS][`NPU_MAX_DIM];
    elem_t   w_m [`NPU_W_SLOTS][`NPU_MAX_DIM][`NPU_MAX_DIM];
    result_t model_res;

    npu_exec_top npu_exec_top_inst (
        .clk     (clk),
        .rst     (rst),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .result  (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // Fill mode 0 is random, 1 is all +127, 2 is all -128 and 3 is small random values
    function automatic tile_t fill_tile(input int mode);
        tile_t t;
        t = tile_t'($random(seed));
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            if (mode == 1) begin
                t[i] = elem_t'(127);
            end else if (mode == 2) begin
                t[i] = elem_t'(-128);
            end else if (mode == 3) begin
                t[i] = elem_t'(t[i] >>> 4);
            end
        end
        return t;
    endfunction

    function automatic cmd_t make_load(input logic [4:0] op, input int slot, input int row,
                                       input int tidx, input tile_t t);
        cmd_t c;
        c                     = '0;
        c.opcode              = op;
        c.payload.ld.tile     = t;
        c.payload.ld.slot     = slot_t'(slot);
        c.payload.ld.row      = row_t'(row);
        c.payload.ld.tile_idx = tidx_t'(tidx);
        return c;
    endfunction

    function automatic cmd_t make_compute(input logic [4:0] op, input int x_id, input int w_id,
                                          input int b_id, input int rows, input int cols);
        cmd_t c;
        c                 = '0;
        c.opcode          = op;
        c.payload.cp.x_id = slot_t'(x_id);
        c.payload.cp.w_id = slot_t'(w_id);
        c.payload.cp.b_id = slot_t'(b_id);
        c.payload.cp.rows = dim_t'(rows);
        c.payload.cp.cols = dim_t'(cols);
        return c;
    endfunction

    // Clamp to the signed 8-bit range
    function automatic elem_t saturate(input int v);
        if (v > 127) begin
            return elem_t'(127);
        end else if (v < -128) begin
            return elem_t'(-128);
        end
        return elem_t'(v);
    endfunction

    function automatic result_t ref_gemv(input int x_id, input int w_id, input int b_id,
                                         input int rows, input int cols);
        result_t r;
        int      acc;
        r = '0;
        for (int row = 0; row < rows; row++) begin
            acc = int'(vec_m[b_id][row]);
            for (int c = 0; c < cols; c++) begin
                acc += int'(vec_m[x_id][c]) * int'(w_m[w_id][row][c]);
            end
            r[row] = saturate(acc);
        end
        return r;
    endfunction

    function automatic result_t ref_relu(input int x_id, input int cols);
        result_t r;
        r = '0;
        for (int e = 0; e < cols; e++) begin
            r[e] = (vec_m[x_id][e] < 0) ? elem_t'(0) : vec_m[x_id][e];
        end
        return r;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // Full four-phase handshake
    // An exp_lat below zero skips the latency check
    task automatic run_cmd(input cmd_t c, input int exp_lat, input int hold,
                           input result_t exp_res);
        int lat;
        int drop;
        last_opcode = c.opcode;
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        // Counted from the first edge that sees the request
        lat = -1;
        @(negedge clk);
        while (!cmd_ack) begin
            lat++;
            @(negedge clk);
        end
        if (exp_lat >= 0) begin
            check_value(lat, exp_lat, "cycles from request to cmd_ack");
        end
        check_value(result, exp_res, "result while cmd_ack is high");
        // Back-pressure with req kept high
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value(cmd_ack, 1'b1, "cmd_ack while cmd_req held high");
            check_value(result, exp_res, "result stable while cmd_req held high");
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        drop = 0;
        @(negedge clk);
        while (cmd_ack) begin
            drop++;
            @(negedge clk);
        end
        check_value(drop, 1, "cycles from request drop to cmd_ack drop");
    endtask

    task automatic load_vec_tile(input int slot, input int tidx, input int mode, input int hold);
        tile_t t;
        t = fill_tile(mode);
        run_cmd(make_load(`NPU_OP_LOAD_V, slot, 0, tidx, t), 2, hold, model_res);
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            vec_m[slot][tidx * `NPU_TILE_ELEMS + i] = t[i];
        end
    endtask

    task automatic load_weight_tile(input int slot, input int row, input int tidx,
                                    input int mode, input int hold);
        tile_t t;
        t = fill_tile(mode);
        run_cmd(make_load(`NPU_OP_LOAD_M, slot, row, tidx, t), 2, hold, model_res);
        for (int i = 0; i < `NPU_TILE_ELEMS; i++) begin
            w_m[slot][row][tidx * `NPU_TILE_ELEMS + i] = t[i];
        end
    endtask

    task automatic run_gemv(input int x_id, input int w_id, input int b_id,
                            input int rows, input int cols, input int hold);
        model_res = ref_gemv(x_id, w_id, b_id, rows, cols);
        run_cmd(make_compute(`NPU_OP_GEMV, x_id, w_id, b_id, rows, cols), -1, hold, model_res);
    endtask

    // One tile per cycle and at least one tile even for zero columns
    task automatic run_relu(input int x_id, input int cols, input int hold);
        int tiles;
        tiles     = (cols == 0) ? 1 : (cols + `NPU_TILE_ELEMS - 1) / `NPU_TILE_ELEMS;
        model_res = ref_relu(x_id, cols);
        run_cmd(make_compute(`NPU_OP_RELU, x_id, 0, 0, 0, cols), 2 + tiles, hold, model_res);
    endtask

    // NOP or unknown opcode with a random payload
    task automatic run_no_effect(input logic [4:0] op, input int hold);
        cmd_t        c;
        logic [63:0] bits;
        bits      = {$random(seed), $random(seed)};
        c.opcode  = op;
        c.payload = bits[$bits(cmd_u)-1:0];
        run_cmd(c, 2, hold, model_res);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("Test %s: PASS, %0d checks", test_name, checks - test_checks);
        end else begin
            failed_tests++;
            $display("Test %s: FAIL, %0d of %0d checks wrong", test_name,
                     errors - test_errors, checks - test_checks);
        end
    endtask

    initial begin
        int         x_id;
        int         w_id;
        int         b_id;
        int         mode;
        int         x_mode;
        int         w_mode;
        logic [4:0] op;
        seed         = 20;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        last_opcode  = '0;
        model_res    = '0;
        clk          = 1'b0;
        rst          = 1'b1;
        cmd_req      = 1'b0;
        cmd          = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        begin_test("reset_state");
        check_value(cmd_ack, 1'b0, "cmd_ack after reset");
        check_value(result, '0, "result after reset");
        end_test();

        // Every buffer word gets defined data first
        begin_test("fill_buffers");
        for (int s = 0; s < `NPU_VEC_SLOTS; s++) begin
            for (int t = 0; t < `NPU_TILES_PER_VEC; t++) begin
                load_vec_tile(s, t, 0, 0);
            end
        end
        for (int s = 0; s < `NPU_W_SLOTS; s++) begin
            for (int r = 0; r < `NPU_MAX_DIM; r++) begin
                for (int t = 0; t < `NPU_TILES_PER_VEC; t++) begin
                    load_weight_tile(s, r, t, 0, 0);
                end
            end
        end
        end_test();

        begin_test("relu_random");
        for (int n = 0; n < N_RELU; n++) begin
            x_id = rand_range(0, `NPU_VEC_SLOTS - 1);
            load_vec_tile(x_id, 0, 0, 0);
            load_vec_tile(x_id, 1, 0, 0);
            run_relu(x_id, rand_range(0, `NPU_MAX_DIM), 0);
        end
        end_test();

        // Mode 1 uses small values so most sums stay in range
        // Modes 2 and 3 drive the sums into positive and negative saturation
        begin_test("gemv_random");
        for (int n = 0; n < N_GEMV; n++) begin
            mode = n % 4;
            if (mode == 1) begin
                x_mode = 3;
                w_mode = 3;
            end else if (mode >= 2) begin
                x_mode = 1;
                w_mode = mode - 1;
            end else begin
                x_mode = 0;
                w_mode = 0;
            end
            x_id = rand_range(0, `NPU_VEC_SLOTS - 1);
            b_id = rand_range(0, `NPU_VEC_SLOTS - 1);
            w_id = rand_range(0, `NPU_W_SLOTS - 1);
            for (int t = 0; t < `NPU_TILES_PER_VEC; t++) begin
                load_vec_tile(b_id, t, 0, 0);
            end
            for (int t = 0; t < `NPU_TILES_PER_VEC; t++) begin
                load_vec_tile(x_id, t, x_mode, 0);
            end
            for (int r = 0; r < `NPU_MAX_DIM; r++) begin
                for (int t = 0; t < `NPU_TILES_PER_VEC; t++) begin
                    load_weight_tile(w_id, r, t, w_mode, 0);
                end
            end
            run_gemv(x_id, w_id, b_id, rand_range(0, `NPU_MAX_DIM),
                     rand_range((mode >= 2) ? 1 : 0, `NPU_MAX_DIM), rand_range(0, 3));
        end
        end_test();

        begin_test("overwrite_rerun");
        for (int n = 0; n < N_OVER; n++) begin
            x_id = rand_range(0, `NPU_VEC_SLOTS - 1);
            b_id = rand_range(0, `NPU_VEC_SLOTS - 1);
            w_id = rand_range(0, `NPU_W_SLOTS - 1);
            run_gemv(x_id, w_id, b_id, `NPU_MAX_DIM, `NPU_MAX_DIM, 0);
            load_vec_tile(x_id, rand_range(0, 1), 0, 0);
            load_weight_tile(w_id, rand_range(0, `NPU_MAX_DIM - 1), rand_range(0, 1), 0, 0);
            run_gemv(x_id, w_id, b_id, `NPU_MAX_DIM, `NPU_MAX_DIM, 0);
        end
        end_test();

        begin_test("nop_unknown");
        for (int n = 0; n < N_NOP; n++) begin
            if (n % 2 == 0) begin
                op = `NPU_OP_NOP;
            end else begin
                // Opcode map gaps are 3 and 6 to 31
                op = (rand_range(0, 3) == 0) ? 5'd3 : 5'(rand_range(6, 31));
            end
            run_no_effect(op, rand_range(0, 2));
        end
        end_test();

        begin_test("hold_request");
        for (int n = 0; n < N_HOLD; n++) begin
            x_id = rand_range(0, `NPU_VEC_SLOTS - 1);
            if (n % 2 == 0) begin
                run_relu(x_id, rand_range(1, `NPU_MAX_DIM), rand_range(1, 12));
            end else begin
                run_gemv(x_id, rand_range(0, `NPU_W_SLOTS - 1), rand_range(0, 7),
                         rand_range(1, `NPU_MAX_DIM), rand_range(1, `NPU_MAX_DIM),
                         rand_range(1, 12));
            end
        end
        end_test();

        begin_test("load_latency");
        for (int n = 0; n < N_LAT; n++) begin
            if (rand_range(0, 1) == 0) begin
                load_vec_tile(rand_range(0, `NPU_VEC_SLOTS - 1), rand_range(0, 1), 0,
                              rand_range(0, 3));
            end else begin
                load_weight_tile(rand_range(0, `NPU_W_SLOTS - 1),
                                 rand_range(0, `NPU_MAX_DIM - 1), rand_range(0, 1), 0,
                                 rand_range(0, 3));
            end
        end
        // Loaded data reaches the datapath
        run_gemv(rand_range(0, 7), rand_range(0, 3), rand_range(0, 7), 8, 8, 0);
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the command bound
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: no finish within %0d ns, opcode %0d stuck in its handshake",
                 TIMEOUT_NS, last_opcode);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
npu_pkg.sv
tile_buffer.sv
gemv_engine.sv
result_store.sv
exec_ctrl.sv
npu_exec_top.sv
tb_npu_exec.sv

// File: Makefile
# Verilator flow for the NPU execution unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_npu_exec

# Simulator status kept, then the log is searched for the fail message
run: compile
	./obj_dir/Vtb_npu_exec > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Simulation failed" sim.log; then \
		echo "Run reported failure, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
